// File: design/ex_mem_reg.sv
`timescale 1ns/1ns

module ex_mem_reg (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  mips_exec_pkg::ex_out_t ex,
    input  logic                   stall,
    output mips_exec_pkg::ex_out_t wb
);

    logic capture;

    // nothing moves while the multiplier holds the stage
    assign capture = ex.valid && !stall;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= capture;   // pulse per result
            if (capture) begin
                wb.result  <= ex.result;
                wb.do_jump <= ex.do_jump;
                wb.j_addr  <= ex.j_addr;
            end
        end
    end

endmodule

// File: design/exec_stage_top.sv
`timescale 1ns/1ns

module exec_stage_top (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  logic                   in_valid,   // one-cycle strobe
    input  logic [31:0]            ins,
    input  logic [31:0]            reg1,
    input  logic [31:0]            reg2,
    input  logic [31:0]            next_pc,
    output mips_exec_pkg::ex_out_t wb,
    output logic                   stall
);

    mips_exec_pkg::dec_t    dec_bus;
    mips_exec_pkg::ex_out_t ex_bus;

    instr_decoder u_decoder (
        .ins      (ins),
        .in_valid (in_valid),
        .dec      (dec_bus)
    );

    execute u_execute (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .dec     (dec_bus),
        .reg1    (reg1),
        .reg2    (reg2),
        .next_pc (next_pc),
        .ex      (ex_bus),
        .stall   (stall)
    );

    // execute/memory boundary
    ex_mem_reg u_ex_mem (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .ex      (ex_bus),
        .stall   (stall),
        .wb      (wb)
    );

endmodule

// File: design/execute.sv
`timescale 1ns/1ns

module execute (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  mips_exec_pkg::dec_t    dec,
    input  logic [31:0]            reg1,     // rs
    input  logic [31:0]            reg2,     // rt
    input  logic [31:0]            next_pc,
    output mips_exec_pkg::ex_out_t ex,
    output logic                   stall     // multiplier busy
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  shamt;
    logic [4:0]  rt_id;
    logic        r_op;
    logic        is_regimm;
    logic        is_def;
    logic        is_aui;
    logic        is_jr;
    logic [2:0]  def_exe;
    logic [31:0] op2;
    logic [31:0] inv_op2;
    logic [31:0] alu_out;
    logic        set_bit;
    logic        set_unsign;
    logic [4:0]  real_shamt;
    logic [31:0] shift_out;
    logic        do_branch;
    logic [63:0] mul_out;
    logic        mul_done;
    logic        mul_low;
    logic [31:0] mul_word;
    logic        mul_pending;
    logic        valid_held;
    logic [31:0] result;
    logic        do_jump;
    logic [31:0] j_addr;

    assign opcode    = dec.ins.r.opcode;
    assign funct     = dec.ins.r.funct;
    assign shamt     = dec.ins.r.shamt;
    assign rt_id     = dec.ins.i.rt;
    assign r_op      = opcode == mips_exec_pkg::OP_RTYPE;
    assign is_regimm = opcode == mips_exec_pkg::OP_REGIMM;
    assign is_aui    = opcode == mips_exec_pkg::OP_AUI;

    // arithmetic and logic group, loads and stores reuse addiu
    assign is_def  = opcode[5:3] == 3'b001 || (r_op && funct[5:3] == 3'b100) ||
                     dec.ctrl.is_load_store;
    assign def_exe = dec.ctrl.is_load_store ? 3'b001 : (r_op ? funct[2:0] : opcode[2:0]);
    assign op2     = dec.ctrl.alu_src ? dec.immd : reg2;
    assign inv_op2 = ~op2 + 32'd1;

    always_comb begin
        case (def_exe)
            3'b000, 3'b001: alu_out = reg1 + op2;        // no overflow trap
            3'b010, 3'b011: alu_out = reg1 + inv_op2;
            3'b100:         alu_out = reg1 & op2;
            3'b101:         alu_out = reg1 | op2;
            3'b110:         alu_out = reg1 ^ op2;
            default: begin
                if (is_aui)
                    alu_out = {dec.ins.i.imm16, 16'b0} + reg1;
                else
                    alu_out = ~(reg1 | op2);              // nor
            end
        endcase
    end

    // set checker, op2 is already reg2 or immd
    assign set_unsign = r_op ? funct[0] : opcode[0];
    assign set_bit    = set_unsign ? (reg1 < op2) : ($signed(reg1) < $signed(op2));

    // shifter, variable forms take the amount from rs
    assign real_shamt = funct[2] ? reg1[4:0] : shamt;
    always_comb begin
        case (funct[1:0])
            2'b00:   shift_out = reg2 << real_shamt;
            2'b10:   shift_out = reg2 >> real_shamt;
            2'b11:   shift_out = $signed(reg2) >>> real_shamt;
            default: shift_out = 32'd0;                  // not a shift
        endcase
    end

    // branch comparator
    always_comb begin
        if (is_regimm) begin
            case (rt_id)
                mips_exec_pkg::RT_BGEZ: do_branch = !reg1[31];
                mips_exec_pkg::RT_BAL:  do_branch = 1'b1;
                default:                do_branch = 1'b0;
            endcase
        end else begin
            case (opcode[1:0])
                2'b00:   do_branch = reg1 == reg2;           // beq
                2'b01:   do_branch = reg1 != reg2;           // bne
                2'b10:   do_branch = $signed(reg1) <= 0;     // blez
                default: do_branch = $signed(reg1) > 0;      // bgtz
            endcase
        end
    end

    // mul request is remembered after the strobe until done
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            mul_pending <= 1'b0;
        end else if (mul_done) begin
            mul_pending <= 1'b0;
        end else if (dec.valid && dec.ctrl.is_mul) begin
            mul_pending <= 1'b1;
        end
    end

    assign valid_held = dec.valid || mul_pending;
    assign stall      = dec.ctrl.is_mul && valid_held && !mul_done;
    assign mul_low    = shamt == mips_exec_pkg::SHAMT_MUL_LO;
    assign mul_word   = mul_low ? mul_out[31:0] : mul_out[63:32];

    multiplier u_mult (
        .clk       (sys_clk),
        .rst_n     (rst_n),
        .enable    (stall),         // dropped during done, no restart
        .is_unsign (funct[0]),
        .a         (reg1),
        .b         (reg2),
        .result    (mul_out),
        .done      (mul_done)
    );

    // result mux, first match wins
    always_comb begin
        if (dec.ctrl.is_set)
            result = {31'b0, set_bit};
        else if (dec.ctrl.is_mul)
            result = mul_word;
        else if (is_def)
            result = alu_out;
        else if (dec.ctrl.is_shift)
            result = shift_out;
        else if (dec.ctrl.is_link)
            result = next_pc + 32'd4;
        else
            result = 32'd0;
    end

    // jumps and taken branches
    assign is_jr = r_op && (funct == mips_exec_pkg::FN_JR || funct == mips_exec_pkg::FN_JALR);
    always_comb begin
        if (dec.ctrl.is_jump) begin
            do_jump = 1'b1;
            j_addr  = is_jr ? reg1 : {next_pc[31:28], dec.ins.j.target26, 2'b00};
        end else if (dec.ctrl.is_branch && do_branch) begin
            do_jump = 1'b1;
            j_addr  = next_pc + {dec.immd[29:0], 2'b00};
        end else begin
            do_jump = 1'b0;
            j_addr  = 32'd0;
        end
    end

    assign ex = '{
        result:  result,
        do_jump: do_jump,
        j_addr:  j_addr,
        valid:   valid_held && !stall
    };

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  logic [31:0]         ins,
    input  logic                in_valid,
    output mips_exec_pkg::dec_t dec
);

    mips_exec_pkg::instr_t word;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;
    logic [15:0] imm16;
    logic is_r;
    logic is_regimm;
    logic zero_ext;

    assign word      = ins;
    assign opcode    = word.r.opcode;
    assign funct     = word.r.funct;
    assign rt        = word.i.rt;
    assign imm16     = word.i.imm16;
    assign is_r      = opcode == mips_exec_pkg::OP_RTYPE;
    assign is_regimm = opcode == mips_exec_pkg::OP_REGIMM;

    // logical immediates are zero extended
    assign zero_ext = opcode == mips_exec_pkg::OP_ANDI ||
                      opcode == mips_exec_pkg::OP_ORI  ||
                      opcode == mips_exec_pkg::OP_XORI;

    always_comb begin
        dec.ins   = word;
        dec.valid = in_valid;
        dec.immd  = zero_ext ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

        // all i-type alu ops sit in 001xxx
        dec.ctrl.alu_src = opcode[5:3] == 3'b001 ||
                           opcode == mips_exec_pkg::OP_LW ||
                           opcode == mips_exec_pkg::OP_SW;

        dec.ctrl.is_link = opcode == mips_exec_pkg::OP_JAL ||
                           (is_r && funct == mips_exec_pkg::FN_JALR) ||
                           (is_regimm && rt == mips_exec_pkg::RT_BAL);

        dec.ctrl.is_jump = opcode == mips_exec_pkg::OP_J ||
                           opcode == mips_exec_pkg::OP_JAL ||
                           (is_r && (funct == mips_exec_pkg::FN_JR ||
                                     funct == mips_exec_pkg::FN_JALR));

        // beq, bne, blez, bgtz share 0001xx
        dec.ctrl.is_branch = opcode[5:2] == 4'b0001 ||
                             (is_regimm && (rt == mips_exec_pkg::RT_BGEZ ||
                                            rt == mips_exec_pkg::RT_BAL));

        dec.ctrl.is_load_store = opcode == mips_exec_pkg::OP_LW ||
                                 opcode == mips_exec_pkg::OP_SW;

        dec.ctrl.is_mul = is_r && (funct == mips_exec_pkg::FN_MUL ||
                                   funct == mips_exec_pkg::FN_MULU);

        dec.ctrl.is_shift = is_r && funct[5:3] == 3'b000;  // sll .. srav

        dec.ctrl.is_set = opcode == mips_exec_pkg::OP_SLTI ||
                          opcode == mips_exec_pkg::OP_SLTIU ||
                          (is_r && (funct == mips_exec_pkg::FN_SLT ||
                                    funct == mips_exec_pkg::FN_SLTU));
    end

endmodule

// File: design/mips_exec_pkg.sv
package mips_exec_pkg;

    // major opcodes
    localparam logic [5:0] OP_RTYPE  = 6'b000000;
    localparam logic [5:0] OP_REGIMM = 6'b000001;
    localparam logic [5:0] OP_J      = 6'b000010;
    localparam logic [5:0] OP_JAL    = 6'b000011;
    localparam logic [5:0] OP_BEQ    = 6'b000100;
    localparam logic [5:0] OP_BNE    = 6'b000101;
    localparam logic [5:0] OP_BLEZ   = 6'b000110;
    localparam logic [5:0] OP_BGTZ   = 6'b000111;
    localparam logic [5:0] OP_ADDI   = 6'b001000;
    localparam logic [5:0] OP_ADDIU  = 6'b001001;
    localparam logic [5:0] OP_SLTI   = 6'b001010;
    localparam logic [5:0] OP_SLTIU  = 6'b001011;
    localparam logic [5:0] OP_ANDI   = 6'b001100;
    localparam logic [5:0] OP_ORI    = 6'b001101;
    localparam logic [5:0] OP_XORI   = 6'b001110;
    localparam logic [5:0] OP_AUI    = 6'b001111;   // lui when rs is $0
    localparam logic [5:0] OP_LW     = 6'b100011;
    localparam logic [5:0] OP_SW     = 6'b101011;

    // r-type funct field
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_MUL  = 6'b011000;   // mul/muh, picked by shamt
    localparam logic [5:0] FN_MULU = 6'b011001;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // regimm rt selectors
    localparam logic [4:0] RT_BGEZ = 5'b00001;
    localparam logic [4:0] RT_BAL  = 5'b10001;

    localparam logic [4:0] SHAMT_MUL_LO = 5'b00010;  // 3 selects the high word
    localparam int MUL_CYCLES = 32;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } j_fmt_t;

    // one word, three views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_t;

    typedef struct packed {
        logic alu_src;        // 1 selects immd as operand 2
        logic is_link;
        logic is_jump;
        logic is_branch;
        logic is_load_store;
        logic is_mul;
        logic is_shift;
        logic is_set;
    } ctrl_t;

    typedef struct packed {
        instr_t      ins;
        logic [31:0] immd;
        logic        valid;
        ctrl_t       ctrl;
    } dec_t;

    typedef struct packed {
        logic [31:0] result;
        logic        do_jump;
        logic [31:0] j_addr;
        logic        valid;
    } ex_out_t;

endpackage

// File: design/multiplier.sv
`timescale 1ns/1ns

module multiplier (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,
    input  logic        is_unsign,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [63:0] result,
    output logic        done
);

    logic busy;
    logic [$clog2(mips_exec_pkg::MUL_CYCLES)-1:0] step_cnt;
    logic start;
    logic last_step;
    logic a_neg;
    logic b_neg;
    logic neg;
    logic [31:0] a_mag;
    logic [63:0] prod;         // {partial sum, remaining multiplier bits}
    logic [32:0] psum;
    logic [63:0] prod_next;

    assign start     = enable && !busy && !done;
    assign last_step = busy && int'(step_cnt) == mips_exec_pkg::MUL_CYCLES - 1;
    assign a_neg     = !is_unsign && a[31];
    assign b_neg     = !is_unsign && b[31];

    // add on lsb, then shift right
    assign psum      = {1'b0, prod[63:32]} + (prod[0] ? {1'b0, a_mag} : 33'd0);
    assign prod_next = {psum, prod[31:1]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= last_step;  // one-cycle pulse
            if (start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_mag <= a_neg ? -a : a;   // 0x80000000 stays as 2^31
            prod  <= {32'b0, b_neg ? -b : b};
            neg   <= a_neg ^ b_neg;
        end else if (busy) begin
            prod <= prod_next;
            if (last_step)
                result <= neg ? -prod_next : prod_next;
        end
    end

endmodule

// File: sources.f
design/mips_exec_pkg.sv
design/instr_decoder.sv
design/multiplier.sv
design/execute.sv
design/ex_mem_reg.sv
design/exec_stage_top.sv
verification/tb_clock_gen.sv
verification/exec_stage_tb.sv

// File: verification/exec_stage_tb.sv
`timescale 1ns/1ns

module exec_stage_tb;

    localparam int TIMEOUT = 100;   // cycles per wait

    logic                   sys_clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [31:0]            ins;
    logic [31:0]            reg1;
    logic [31:0]            reg2;
    logic [31:0]            next_pc;
    mips_exec_pkg::ex_out_t wb;
    logic                   stall;

    integer seed = 22;
    int     errors = 0;
    int     mark;
    int     tests_passed = 0;
    int     tests_failed = 0;
    logic   started = 1'b0;     // first strobe seen
    string  cur_name;
    logic [31:0] rnd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
    logic [31:0] w;
    mips_exec_pkg::ex_out_t e;
    mips_exec_pkg::ex_out_t exp_q[$];

    // operation tables, indexed by pick_ins
    logic [5:0] alu_fn [10] = '{mips_exec_pkg::FN_ADD, mips_exec_pkg::FN_ADDU,
        mips_exec_pkg::FN_SUB, mips_exec_pkg::FN_SUBU, mips_exec_pkg::FN_AND,
        mips_exec_pkg::FN_OR, mips_exec_pkg::FN_XOR, mips_exec_pkg::FN_NOR,
        mips_exec_pkg::FN_SLT, mips_exec_pkg::FN_SLTU};
    logic [5:0] imm_op [10] = '{mips_exec_pkg::OP_ADDI, mips_exec_pkg::OP_ADDIU,
        mips_exec_pkg::OP_SLTI, mips_exec_pkg::OP_SLTIU, mips_exec_pkg::OP_ANDI,
        mips_exec_pkg::OP_ORI, mips_exec_pkg::OP_XORI, mips_exec_pkg::OP_AUI,
        mips_exec_pkg::OP_LW, mips_exec_pkg::OP_SW};
    logic [5:0] sh_fn [6] = '{mips_exec_pkg::FN_SLL, mips_exec_pkg::FN_SRL,
        mips_exec_pkg::FN_SRA, mips_exec_pkg::FN_SLLV, mips_exec_pkg::FN_SRLV,
        mips_exec_pkg::FN_SRAV};
    // neg x neg, min x min, min x -1, max x min
    logic [31:0] corner_a [4] = '{32'hffff_fffb, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff};
    logic [31:0] corner_b [4] = '{32'hffff_fff9, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000};

    tb_clock_gen u_clk (.clk(sys_clk));

    exec_stage_top UUT (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .ins      (ins),
        .reg1     (reg1),
        .reg2     (reg2),
        .next_pc  (next_pc),
        .wb       (wb),
        .stall    (stall)
    );

    // outputs stay quiet until the first strobe
    assert property (@(posedge sys_clk) disable iff (!rst_n)
        !started |-> !wb.valid && !wb.do_jump && !stall)
        else begin
            $display("[ERROR] reset_state expected valid/jump/stall 000 actual %b%b%b",
                     $sampled(wb.valid), $sampled(wb.do_jump), $sampled(stall));
            errors++;
        end

    assert property (@(posedge sys_clk) disable iff (!rst_n) stall |-> !wb.valid)
        else begin
            $display("wb.valid was high while the stage was stalled");
            errors++;
        end

    // stall only drops for the capture of the product
    assert property (@(posedge sys_clk) disable iff (!rst_n) $fell(stall) |=> wb.valid)
        else begin
            $display("stall fell but no multiply result was captured");
            errors++;
        end

    task automatic mismatch(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("[ERROR] %s %s expected %h actual %h", cur_name, what, expected, actual);
        errors++;
    endtask

    function automatic logic [31:0] pick_ins(input int sel, input logic [31:0] r);
        if (sel < 10)
            return {mips_exec_pkg::OP_RTYPE, r[25:6], alu_fn[sel]};
        else if (sel < 20)
            return {imm_op[sel-10], r[25:0]};
        else
            return {mips_exec_pkg::OP_RTYPE, r[25:6], sh_fn[sel-20]};
    endfunction

    // expected values from the instruction set rules
    task automatic model(input logic [31:0] wd, input logic [31:0] x, input logic [31:0] y,
                         input logic [31:0] npc, output mips_exec_pkg::ex_out_t r);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [63:0] prod;
        logic        taken;
        op    = wd[31:26];
        fn    = wd[5:0];
        sa    = wd[10:6];
        sx    = {{16{wd[15]}}, wd[15:0]};
        zx    = {16'b0, wd[15:0]};
        taken = 1'b0;
        r     = '0;
        r.valid = 1'b1;
        case (op)
            mips_exec_pkg::OP_RTYPE: begin
                case (fn)
                    mips_exec_pkg::FN_ADD, mips_exec_pkg::FN_ADDU: r.result = x + y;
                    mips_exec_pkg::FN_SUB, mips_exec_pkg::FN_SUBU: r.result = x - y;
                    mips_exec_pkg::FN_AND:  r.result = x & y;
                    mips_exec_pkg::FN_OR:   r.result = x | y;
                    mips_exec_pkg::FN_XOR:  r.result = x ^ y;
                    mips_exec_pkg::FN_NOR:  r.result = ~(x | y);
                    mips_exec_pkg::FN_SLT:  r.result = {31'b0, $signed(x) < $signed(y)};
                    mips_exec_pkg::FN_SLTU: r.result = {31'b0, x < y};
                    mips_exec_pkg::FN_SLL:  r.result = y << sa;
                    mips_exec_pkg::FN_SRL:  r.result = y >> sa;
                    mips_exec_pkg::FN_SRA:  r.result = $signed(y) >>> sa;
                    mips_exec_pkg::FN_SLLV: r.result = y << x[4:0];
                    mips_exec_pkg::FN_SRLV: r.result = y >> x[4:0];
                    mips_exec_pkg::FN_SRAV: r.result = $signed(y) >>> x[4:0];
                    mips_exec_pkg::FN_JR, mips_exec_pkg::FN_JALR: begin
                        r.do_jump = 1'b1;
                        r.j_addr  = x;
                        if (fn == mips_exec_pkg::FN_JALR)
                            r.result = npc + 32'd4;
                    end
                    mips_exec_pkg::FN_MUL, mips_exec_pkg::FN_MULU: begin
                        if (fn == mips_exec_pkg::FN_MULU)
                            prod = {32'b0, x} * {32'b0, y};
                        else
                            prod = {{32{x[31]}}, x} * {{32{y[31]}}, y};  // low 64 bits
                        r.result = sa == mips_exec_pkg::SHAMT_MUL_LO ? prod[31:0] : prod[63:32];
                    end
                    default: r.result = 32'd0;
                endcase
            end
            mips_exec_pkg::OP_ADDI, mips_exec_pkg::OP_ADDIU,
            mips_exec_pkg::OP_LW, mips_exec_pkg::OP_SW: r.result = x + sx;
            mips_exec_pkg::OP_SLTI:  r.result = {31'b0, $signed(x) < $signed(sx)};
            mips_exec_pkg::OP_SLTIU: r.result = {31'b0, x < sx};
            mips_exec_pkg::OP_ANDI:  r.result = x & zx;
            mips_exec_pkg::OP_ORI:   r.result = x | zx;
            mips_exec_pkg::OP_XORI:  r.result = x ^ zx;
            mips_exec_pkg::OP_AUI:   r.result = x + {wd[15:0], 16'b0};
            mips_exec_pkg::OP_J, mips_exec_pkg::OP_JAL: begin
                r.do_jump = 1'b1;
                r.j_addr  = {npc[31:28], wd[25:0], 2'b00};
                if (op == mips_exec_pkg::OP_JAL)
                    r.result = npc + 32'd4;
            end
            mips_exec_pkg::OP_BEQ:  taken = x == y;
            mips_exec_pkg::OP_BNE:  taken = x != y;
            mips_exec_pkg::OP_BLEZ: taken = $signed(x) <= 0;
            mips_exec_pkg::OP_BGTZ: taken = $signed(x) > 0;
            mips_exec_pkg::OP_REGIMM: begin
                taken = wd[20:16] == mips_exec_pkg::RT_BAL || !x[31];
                if (wd[20:16] == mips_exec_pkg::RT_BAL)
                    r.result = npc + 32'd4;
            end
            default: r.result = 32'd0;
        endcase
        if (taken) begin
            r.do_jump = 1'b1;
            r.j_addr  = npc + {sx[29:0], 2'b00};
        end
    endtask

    task automatic compare(input mips_exec_pkg::ex_out_t r);
        assert (wb.result == r.result)
            else mismatch("result", r.result, wb.result);
        assert (wb.do_jump == r.do_jump)
            else mismatch("do_jump", {31'b0, r.do_jump}, {31'b0, wb.do_jump});
        assert (wb.j_addr == r.j_addr)
            else mismatch("j_addr", r.j_addr, wb.j_addr);
    endtask

    // one strobe, then wait for wb.valid
    task automatic run_one(input string name, input logic [31:0] wd, input logic [31:0] x,
                           input logic [31:0] y, input logic [31:0] npc);
        mips_exec_pkg::ex_out_t r;
        logic is_mul;
        int   cycles;
        model(wd, x, y, npc, r);
        is_mul = wd[31:26] == mips_exec_pkg::OP_RTYPE &&
                 (wd[5:0] == mips_exec_pkg::FN_MUL || wd[5:0] == mips_exec_pkg::FN_MULU);
        @(negedge sys_clk);
        cur_name = name;
        ins      = wd;
        reg1     = x;
        reg2     = y;
        next_pc  = npc;
        in_valid = 1'b1;
        started  = 1'b1;
        @(negedge sys_clk);
        in_valid = 1'b0;   // operands stay put through a stall
        cycles   = 1;
        while (!wb.valid && cycles < TIMEOUT) begin
            @(negedge sys_clk);
            cycles++;
        end
        if (!wb.valid) begin
            $display("timeout: %s gave no valid result within %0d cycles", name, TIMEOUT);
            errors++;
        end else begin
            if (!is_mul)
                assert (cycles == 1) else mismatch("latency", 32'd1, cycles);
            compare(r);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == mark) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - mark);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        ins      = 32'd0;
        reg1     = 32'd0;
        reg2     = 32'd0;
        next_pc  = 32'd0;
        repeat (2) @(negedge sys_clk);
        rst_n = 1'b1;

        mark = errors;
        cur_name = "reset_state";
        repeat (3) begin
            @(negedge sys_clk);
            assert (wb.result == 32'd0 && wb.j_addr == 32'd0)
                else mismatch("result|j_addr", 32'd0, wb.result | wb.j_addr);
        end
        end_test("reset_state");

        mark = errors;
        for (int sel = 0; sel < 20; sel++) begin
            repeat (3) begin
                rnd = $random(seed);
                a   = $random(seed);
                b   = $random(seed);
                w   = pick_ins(sel, rnd);
                run_one($sformatf("op%02h/fn%02h", w[31:26], w[5:0]), w, a, b, 32'h0040_0000);
            end
        end
        rnd = $random(seed);
        run_one("lui", {mips_exec_pkg::OP_AUI, 5'd0, rnd[20:0]}, 32'd0, 32'd0, 32'd0);
        end_test("alu_set");

        mark = errors;
        for (int sel = 20; sel < 26; sel++) begin
            repeat (4) begin
                rnd = $random(seed);
                a   = $random(seed);
                b   = $random(seed);
                w   = pick_ins(sel, rnd);
                run_one($sformatf("shift fn%02h", w[5:0]), w, a, b, 32'd0);
            end
        end
        end_test("shifts");

        mark = errors;
        for (int f = 0; f < 2; f++) begin
            for (int lo = 0; lo < 2; lo++) begin
                for (int k = 0; k < 6; k++) begin
                    a = k < 4 ? corner_a[k] : $random(seed);
                    b = k < 4 ? corner_b[k] : $random(seed);
                    w = {mips_exec_pkg::OP_RTYPE, 5'd1, 5'd2, 5'd0,
                         lo ? mips_exec_pkg::SHAMT_MUL_LO : 5'd3,
                         f ? mips_exec_pkg::FN_MULU : mips_exec_pkg::FN_MUL};
                    run_one($sformatf("%s%s", lo ? "mul" : "muh", f ? "u" : ""), w, a, b, 0);
                end
            end
        end
        end_test("multiply");

        mark = errors;
        rnd = $random(seed);
        pc  = $random(seed) & 32'hffff_fffc;
        run_one("j", {mips_exec_pkg::OP_J, rnd[25:0]}, 0, 0, pc);
        run_one("jal", {mips_exec_pkg::OP_JAL, rnd[25:0]}, 0, 0, pc);
        run_one("jr", {mips_exec_pkg::OP_RTYPE, 5'd4, 15'd0, mips_exec_pkg::FN_JR}, rnd, 0, pc);
        run_one("jalr", {mips_exec_pkg::OP_RTYPE, 5'd4, 5'd0, 5'd31, 5'd0,
                         mips_exec_pkg::FN_JALR}, rnd, 0, pc);
        w = {mips_exec_pkg::OP_BEQ, 5'd1, 5'd2, rnd[15:0]};
        run_one("beq taken", w, rnd, rnd, pc);
        run_one("beq not taken", w, rnd, ~rnd, pc);
        w = {mips_exec_pkg::OP_BNE, 5'd1, 5'd2, rnd[15:0]};
        run_one("bne taken", w, rnd, ~rnd, pc);
        run_one("bne not taken", w, rnd, rnd, pc);
        w = {mips_exec_pkg::OP_BLEZ, 5'd1, 5'd0, rnd[15:0]};
        run_one("blez taken", w, 32'hffff_fffd, 0, pc);
        run_one("blez zero", w, 0, 0, pc);
        run_one("blez not taken", w, 5, 0, pc);
        w = {mips_exec_pkg::OP_BGTZ, 5'd1, 5'd0, rnd[15:0]};
        run_one("bgtz taken", w, 5, 0, pc);
        run_one("bgtz not taken", w, 0, 0, pc);
        w = {mips_exec_pkg::OP_REGIMM, 5'd1, mips_exec_pkg::RT_BGEZ, rnd[15:0]};
        run_one("bgez taken", w, 0, 0, pc);
        run_one("bgez not taken", w, 32'h8000_0001, 0, pc);
        w = {mips_exec_pkg::OP_REGIMM, 5'd0, mips_exec_pkg::RT_BAL, rnd[15:0]};
        run_one("bal", w, 32'h8000_0000, 0, pc);
        end_test("jumps_branches");

        // one strobe per cycle, results checked one cycle behind
        mark = errors;
        for (int k = 0; k <= 20; k++) begin
            @(negedge sys_clk);
            if (k > 0) begin
                cur_name = $sformatf("stream %0d", k - 1);
                e = exp_q.pop_front();
                assert (wb.valid) else mismatch("valid", 32'd1, {31'b0, wb.valid});
                compare(e);
            end
            if (k < 20) begin
                rnd = $random(seed);
                a   = $random(seed);
                b   = $random(seed);
                w   = pick_ins({$random(seed)} % 26, rnd);
                model(w, a, b, 32'h0040_1000, e);
                exp_q.push_back(e);
                ins      = w;
                reg1     = a;
                reg2     = b;
                next_pc  = 32'h0040_1000;
                in_valid = 1'b1;
            end else begin
                in_valid = 1'b0;
            end
        end
        end_test("back_to_back");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule
